// ==== verilog/boot_pkg.sv ====
package boot_pkg;

  // work ram sweep, 128 Ki entries
  localparam int fill_addr_w = 17;

  // rom and ram mask width
  localparam int mask_w = 24;

  // header size code width
  localparam int size_w = 4;

  // parser delay counter
  localparam int parser_cnt_w = 3;
  localparam logic [parser_cnt_w-1:0] parser_delay_init = 3'd6;
  // counter rests here after reset, before any download
  localparam logic [parser_cnt_w-1:0] parser_delay_idle = 3'd7;

  // bytes for a size code of zero
  localparam int mask_base = 1024;

  // apb bus widths
  localparam int apb_addr_w = 4;
  localparam int apb_data_w = 32;

  // fill byte type
  typedef logic [7:0] byte_t;

  // fill patterns for work and audio ram
  typedef enum logic [1:0] {
    fill_checker = 2'd0,
    fill_stripe  = 2'd1,
    fill_55      = 2'd2,
    fill_ff      = 2'd3
  } fill_pattern_e;

  // apb register offsets
  typedef enum logic [apb_addr_w-1:0] {
    reg_pattern_addr = 4'h0,
    reg_status_addr  = 4'h4
  } apb_reg_e;

endpackage

// ==== verilog/load_tracker.sv ====
module load_tracker
  import boot_pkg::*;
(
  input  logic              clk_sys,
  input  logic              reset,
  input  logic              cart_download,
  input  logic              spc_download,
  input  logic              ioctl_wr,
  input  logic [size_w-1:0] rom_size,
  input  logic [size_w-1:0] ram_size,
  output logic [mask_w-1:0] rom_mask,
  output logic [mask_w-1:0] ram_mask,
  output logic [size_w-1:0] sram_size,
  output logic              parser_busy,
  output logic              downloading,
  output logic              spc_mode
);

  // registered download flags
  logic dl_q;
  // parser delay counter
  logic [parser_cnt_w-1:0] delay_cnt;
  // end of either download
  logic dl_end;

  // any download in progress
  assign downloading = cart_download | spc_download;

  // flags were up last clock, both down now
  assign dl_end = dl_q & ~cart_download & ~spc_download;

  // busy between load and expiry, idle value and zero both mean done
  assign parser_busy = (delay_cnt != parser_delay_idle) && (delay_cnt != '0);

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      dl_q <= 1'b0;
    end else begin
      dl_q <= downloading;
    end
  end

  // delay runs down one per clock after the end event
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      delay_cnt <= parser_delay_idle;
    end else if (dl_end) begin
      delay_cnt <= parser_delay_init;
    end else if (parser_busy) begin
      delay_cnt <= delay_cnt - 1'b1;
    end
  end

  // header fields are settled by now
  // masks must be valid before the core leaves reset
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      rom_mask  <= '0;
      ram_mask  <= '0;
      sram_size <= '0;
    end else if (delay_cnt == parser_cnt_w'(1)) begin
      rom_mask <= (mask_w'(mask_base) << rom_size) - mask_w'(1);
      // no ram at all for a zero code
      if (ram_size == '0) begin
        ram_mask <= '0;
      end else begin
        ram_mask <= (mask_w'(mask_base) << ram_size) - mask_w'(1);
      end
      sram_size <= ram_size;
    end
  end

  // sound program mode follows the last written download type
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      spc_mode <= 1'b0;
    end else if (ioctl_wr) begin
      spc_mode <= spc_download;
    end
  end

endmodule

// ==== verilog/ram_clear.sv ====
module ram_clear
  import boot_pkg::*;
(
  input  logic                   clk_sys,
  input  logic                   reset,
  input  logic                   cart_download,
  input  fill_pattern_e          wram_pattern,
  input  fill_pattern_e          aram_pattern,
  output logic                   clearing,
  output logic [fill_addr_w-1:0] fill_addr,
  output byte_t                  wram_fill_data,
  output byte_t                  aram_fill_data
);

  // previous cart download level
  logic cart_q;
  // quarter rate pacing, ram side is slow
  logic [1:0] clear_div;
  // cart download just started
  logic cart_rise;

  assign cart_rise = cart_download & ~cart_q;

  // byte for one pattern at one address
  function automatic byte_t fill_byte(input fill_pattern_e pat,
                                      input logic [fill_addr_w-1:0] addr);
    byte_t val;
    case (pat)
      // checkerboard on bits 8 and 2
      fill_checker: val = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
      // stripes on bits 9 and 0
      fill_stripe:  val = (addr[9] ^ addr[0]) ? 8'hff : 8'h00;
      fill_55:      val = 8'h55;
      default:      val = 8'hff;
    endcase
    return val;
  endfunction

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      cart_q <= 1'b0;
    end else begin
      cart_q <= cart_download;
    end
  end

  // free running, never held by clearing
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      clear_div <= '0;
    end else begin
      clear_div <= clear_div + 1'b1;
    end
  end

  // start on cart download edge, stop once the sweep hits the top
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      clearing <= 1'b0;
    end else if (&fill_addr) begin
      clearing <= 1'b0;
    end else if (cart_rise) begin
      clearing <= 1'b1;
    end
  end

  // address steps on divider phase zero only
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      fill_addr <= '0;
    end else if (clearing) begin
      if (clear_div == 2'd0) begin
        fill_addr <= fill_addr + 1'b1;
      end
    end else begin
      // parked at zero between clears
      fill_addr <= '0;
    end
  end

  // same decode for both rams, separate selects
  assign wram_fill_data = fill_byte(wram_pattern, fill_addr);
  assign aram_fill_data = fill_byte(aram_pattern, fill_addr);

endmodule

// ==== verilog/reset_sequencer.sv ====
module reset_sequencer (
  input  logic clk_sys,
  input  logic reset,
  input  logic core_reset,
  input  logic downloading,
  input  logic parser_busy,
  input  logic clearing,
  output logic core_reset_n,
  output logic rfsh
);

  // divide by four phase
  logic [1:0] div;
  // any reason to hold the core
  logic hold_core;

  assign hold_core = core_reset | downloading | parser_busy | clearing;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      div          <= '0;
      rfsh         <= 1'b0;
      core_reset_n <= 1'b0;
    end else begin
      div <= div + 1'b1;
      // one refresh pulse per four clocks
      rfsh <= (div == 2'd0);
      // core reset only moves on phase two
      if (div == 2'd2) begin
        core_reset_n <= ~hold_core;
      end
    end
  end

endmodule

// ==== verilog/apb_settings.sv ====
module apb_settings
  import boot_pkg::*;
(
  input  logic                  clk_sys,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic [apb_data_w-1:0] pwdata,
  output logic [apb_data_w-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  clearing,
  input  logic                  spc_mode,
  input  logic                  parser_busy,
  output fill_pattern_e         wram_pattern,
  output fill_pattern_e         aram_pattern
);

  // access phase
  logic access;
  // offset decodes
  logic hit_pattern;
  logic hit_status;
  // address and direction both legal
  logic legal;

  // no wait states
  assign pready = 1'b1;

  assign access      = psel & penable;
  assign hit_pattern = (paddr == reg_pattern_addr);
  assign hit_status  = (paddr == reg_status_addr);

  // status is read only
  assign legal   = hit_pattern | (hit_status & ~pwrite);
  assign pslverr = access & ~legal;

  // pattern register, wram in 1:0, aram in 3:2
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      wram_pattern <= fill_checker;
      aram_pattern <= fill_checker;
    end else if (access && pwrite && hit_pattern) begin
      wram_pattern <= fill_pattern_e'(pwdata[1:0]);
      aram_pattern <= fill_pattern_e'(pwdata[3:2]);
    end
  end

  // read mux
  always_comb begin
    prdata = '0;
    if (hit_pattern) begin
      prdata[3:0] = {aram_pattern, wram_pattern};
    end else if (hit_status) begin
      // clearing, spc mode, parser busy from bit 0 up
      prdata[2:0] = {parser_busy, spc_mode, clearing};
    end
  end

endmodule

// ==== verilog/cart_boot_top.sv ====
module cart_boot_top
  import boot_pkg::*;
(
  input  logic                   clk_sys,
  input  logic                   reset,
  input  logic                   cart_download,
  input  logic                   spc_download,
  input  logic                   ioctl_wr,
  input  logic [size_w-1:0]      rom_size,
  input  logic [size_w-1:0]      ram_size,
  input  logic                   core_reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [apb_addr_w-1:0]  paddr,
  input  logic [apb_data_w-1:0]  pwdata,
  output logic [apb_data_w-1:0]  prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic [mask_w-1:0]      rom_mask,
  output logic [mask_w-1:0]      ram_mask,
  output logic [size_w-1:0]      sram_size,
  output logic                   core_reset_n,
  output logic                   rfsh,
  output logic                   clearing,
  output logic [fill_addr_w-1:0] fill_addr,
  output byte_t                  wram_fill_data,
  output byte_t                  aram_fill_data
);

  // tracker to sequencer and status
  logic parser_busy;
  logic downloading;
  logic spc_mode;
  // register block to clear engine
  fill_pattern_e wram_pattern;
  fill_pattern_e aram_pattern;

  load_tracker u_load_tracker (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .cart_download (cart_download),
    .spc_download  (spc_download),
    .ioctl_wr      (ioctl_wr),
    .rom_size      (rom_size),
    .ram_size      (ram_size),
    .rom_mask      (rom_mask),
    .ram_mask      (ram_mask),
    .sram_size     (sram_size),
    .parser_busy   (parser_busy),
    .downloading   (downloading),
    .spc_mode      (spc_mode)
  );

  ram_clear u_ram_clear (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .cart_download  (cart_download),
    .wram_pattern   (wram_pattern),
    .aram_pattern   (aram_pattern),
    .clearing       (clearing),
    .fill_addr      (fill_addr),
    .wram_fill_data (wram_fill_data),
    .aram_fill_data (aram_fill_data)
  );

  // holds the console core while anything above is busy
  reset_sequencer u_reset_sequencer (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .core_reset   (core_reset),
    .downloading  (downloading),
    .parser_busy  (parser_busy),
    .clearing     (clearing),
    .core_reset_n (core_reset_n),
    .rfsh         (rfsh)
  );

  apb_settings u_apb_settings (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .clearing     (clearing),
    .spc_mode     (spc_mode),
    .parser_busy  (parser_busy),
    .wram_pattern (wram_pattern),
    .aram_pattern (aram_pattern)
  );

endmodule

// ==== testbench/tb_cart_boot.sv ====
module tb_cart_boot
  import boot_pkg::*;
();

  localparam int seed = 54691;
  localparam int max_tests = 32;
  localparam int clk_period = 4;
  // worst case sweep, four clocks per fill address
  localparam int clear_clocks = 4 * (2 ** fill_addr_w);

  logic                   clk_sys;
  logic                   reset;
  logic                   cart_download;
  logic                   spc_download;
  logic                   ioctl_wr;
  logic [size_w-1:0]      rom_size;
  logic [size_w-1:0]      ram_size;
  logic                   core_reset;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [apb_addr_w-1:0]  paddr;
  logic [apb_data_w-1:0]  pwdata;
  logic [apb_data_w-1:0]  prdata;
  logic                   pready;
  logic                   pslverr;
  logic [mask_w-1:0]      rom_mask;
  logic [mask_w-1:0]      ram_mask;
  logic [size_w-1:0]      sram_size;
  logic                   core_reset_n;
  logic                   rfsh;
  logic                   clearing;
  logic [fill_addr_w-1:0] fill_addr;
  byte_t                  wram_fill_data;
  byte_t                  aram_fill_data;

  // vector table
  string                  name_mem [max_tests];
  string                  kind_mem [max_tests];
  logic [size_w-1:0]      rom_mem [max_tests];
  logic [size_w-1:0]      ram_mem [max_tests];
  logic [1:0]             wpat_mem [max_tests];
  logic [1:0]             apat_mem [max_tests];
  logic [fill_addr_w-1:0] addr_mem [max_tests][3];
  int                     num_tests = 0;
  logic                   vectors_ready = 1'b0;

  // bookkeeping
  string cur_name = "setup";
  int    error_count = 0;
  int    pass_tests = 0;
  int    fail_tests = 0;
  // clocks seen with clearing high
  int    clear_count = 0;

  cart_boot_top UUT (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .cart_download  (cart_download),
    .spc_download   (spc_download),
    .ioctl_wr       (ioctl_wr),
    .rom_size       (rom_size),
    .ram_size       (ram_size),
    .core_reset     (core_reset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .rom_mask       (rom_mask),
    .ram_mask       (ram_mask),
    .sram_size      (sram_size),
    .core_reset_n   (core_reset_n),
    .rfsh           (rfsh),
    .clearing       (clearing),
    .fill_addr      (fill_addr),
    .wram_fill_data (wram_fill_data),
    .aram_fill_data (aram_fill_data)
  );

  always #2 clk_sys = ~clk_sys;

  always @(negedge clk_sys) begin
    if (clearing === 1'b1) begin
      clear_count <= clear_count + 1;
    end
  end

  // bytes per size code, minus one; code zero on ram means no ram
  function automatic logic [mask_w-1:0] expect_mask(input logic [size_w-1:0] code,
                                                    input logic zero_empty);
    longint bytes;
    if (zero_empty && code == '0) begin
      return '0;
    end
    bytes = longint'(mask_base) * (longint'(1) << code);
    return mask_w'(bytes - 1);
  endfunction

  // fill byte per pattern rule
  function automatic byte_t expect_fill(input logic [1:0] pat,
                                        input logic [fill_addr_w-1:0] addr);
    case (pat)
      fill_checker: return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
      fill_stripe:  return (addr[9] != addr[0]) ? 8'hff : 8'h00;
      fill_55:      return 8'h55;
      default:      return 8'hff;
    endcase
  endfunction

  task automatic report_mismatch(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Fail %0s %0s: expected %0h, actual %0h", cur_name, field, expected, actual);
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("%0s: %0s", cur_name, what);
    error_count++;
  endtask

  task automatic read_vectors();
    int                 fd;
    int                 code;
    int                 rs;
    int                 rz;
    int                 wp;
    int                 ap;
    int                 a0;
    int                 a1;
    int                 a2;
    logic [8*24-1:0]    tok;
    logic [8*8-1:0]     kind;
    logic [8*128-1:0]   junk;
    fd = $fopen("testbench/boot_vectors.txt", "r");
    if (fd == 0) begin
      report_problem("cannot open testbench/boot_vectors.txt");
      return;
    end
    while (!$feof(fd) && num_tests < max_tests) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        break;
      end
      if (string'(tok) == "#") begin
        // rest of a comment line
        code = $fgets(junk, fd);
      end else begin
        code = $fscanf(fd, "%s %d %d %d %d %h %h %h", kind, rs, rz, wp, ap, a0, a1, a2);
        if (code != 8) begin
          report_problem("malformed line in vector file");
          break;
        end
        name_mem[num_tests] = string'(tok);
        kind_mem[num_tests] = string'(kind);
        rom_mem[num_tests] = size_w'(rs);
        ram_mem[num_tests] = size_w'(rz);
        wpat_mem[num_tests] = 2'(wp);
        apat_mem[num_tests] = 2'(ap);
        addr_mem[num_tests][0] = fill_addr_w'(a0);
        addr_mem[num_tests][1] = fill_addr_w'(a1);
        addr_mem[num_tests][2] = fill_addr_w'(a2);
        num_tests++;
      end
    end
    $fclose(fd);
  endtask

  // core_reset stays asserted, caller releases it
  task automatic apply_reset();
    @(negedge clk_sys);
    reset = 1'b0;
    core_reset = 1'b1;
    repeat (2) @(negedge clk_sys);
    reset = 1'b1;
  endtask

  // setup phase, then access phase sampled mid low clock
  task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                            input logic [apb_data_w-1:0] wdata,
                            output logic [apb_data_w-1:0] rdata, output logic err);
    @(negedge clk_sys);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk_sys);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err = pslverr;
    if (pready !== 1'b1) report_mismatch("pready", 32'h1, 32'(pready));
    @(negedge clk_sys);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  // random beat count and gaps, at least four beats
  task automatic run_download(input logic cart);
    int beats;
    int gap;
    beats = 4 + int'($urandom % 16);
    @(negedge clk_sys);
    cart_download = cart;
    spc_download = ~cart;
    repeat (beats) begin
      gap = int'($urandom % 3);
      ioctl_wr = 1'b0;
      repeat (gap) @(negedge clk_sys);
      ioctl_wr = 1'b1;
      @(negedge clk_sys);
    end
    ioctl_wr = 1'b0;
    cart_download = 1'b0;
    spc_download = 1'b0;
  endtask

  task automatic wait_core_release(input int max_clocks);
    int n;
    n = 0;
    while (core_reset_n !== 1'b1 && n < max_clocks) begin
      @(negedge clk_sys);
      n++;
    end
    if (core_reset_n !== 1'b1) begin
      report_problem("core_reset_n did not rise in time");
    end
  endtask

  task automatic test_reset();
    logic [apb_data_w-1:0] rdata;
    logic                  err;
    apply_reset();
    apb_access(1'b0, reg_pattern_addr, '0, rdata, err);
    if (rdata !== '0) report_mismatch("pattern", 32'h0, rdata);
    if (clearing !== 1'b0) report_mismatch("clearing", 32'h0, 32'(clearing));
    if (core_reset_n !== 1'b0) report_mismatch("core_reset_n", 32'h0, 32'(core_reset_n));
    core_reset = 1'b0;
    wait_core_release(8);
  endtask

  task automatic test_apb(input logic [1:0] wp, input logic [1:0] ap);
    logic [apb_data_w-1:0] wdata;
    logic [apb_data_w-1:0] rdata;
    logic                  err;
    wdata = apb_data_w'({ap, wp});
    apb_access(1'b1, reg_pattern_addr, wdata, rdata, err);
    if (err !== 1'b0) report_mismatch("pslverr on pattern write", 32'h0, 32'(err));
    apb_access(1'b0, reg_pattern_addr, '0, rdata, err);
    if (rdata !== wdata) report_mismatch("pattern readback", wdata, rdata);
    // unknown offsets and the read only status word
    apb_access(1'b0, 4'h8, '0, rdata, err);
    if (err !== 1'b1) report_mismatch("pslverr on unknown read", 32'h1, 32'(err));
    if (rdata !== '0) report_mismatch("unknown read data", 32'h0, rdata);
    apb_access(1'b1, 4'hc, ~wdata, rdata, err);
    if (err !== 1'b1) report_mismatch("pslverr on unknown write", 32'h1, 32'(err));
    apb_access(1'b1, reg_status_addr, ~wdata, rdata, err);
    if (err !== 1'b1) report_mismatch("pslverr on status write", 32'h1, 32'(err));
    apb_access(1'b0, reg_pattern_addr, '0, rdata, err);
    if (rdata !== wdata) report_mismatch("pattern after errors", wdata, rdata);
  endtask

  task automatic test_cart(input int idx);
    logic [apb_data_w-1:0]  wdata;
    logic [apb_data_w-1:0]  rdata;
    logic                   err;
    logic [fill_addr_w-1:0] target;
    int                     n;
    int                     early;
    early = 0;
    wdata = apb_data_w'({apat_mem[idx], wpat_mem[idx]});
    apb_access(1'b1, reg_pattern_addr, wdata, rdata, err);
    apb_access(1'b0, reg_pattern_addr, '0, rdata, err);
    if (rdata !== wdata) report_mismatch("pattern readback", wdata, rdata);
    rom_size = rom_mem[idx];
    ram_size = ram_mem[idx];
    run_download(1'b1);
    // clearing set, sound program mode dropped by cart writes
    apb_access(1'b0, reg_status_addr, '0, rdata, err);
    if (rdata[1:0] !== 2'b01) report_mismatch("status", 32'h1, 32'(rdata[1:0]));
    for (int k = 0; k < 3; k++) begin
      target = addr_mem[idx][k];
      n = 0;
      while (fill_addr !== target && clearing === 1'b1 && n < clear_clocks) begin
        if (core_reset_n !== 1'b0) early++;
        @(negedge clk_sys);
        n++;
      end
      if (fill_addr !== target) begin
        report_problem($sformatf("fill address %0h never seen during clear", target));
      end else begin
        if (wram_fill_data !== expect_fill(wpat_mem[idx], target))
          report_mismatch("wram fill", 32'(expect_fill(wpat_mem[idx], target)),
                          32'(wram_fill_data));
        if (aram_fill_data !== expect_fill(apat_mem[idx], target))
          report_mismatch("aram fill", 32'(expect_fill(apat_mem[idx], target)),
                          32'(aram_fill_data));
      end
    end
    n = 0;
    while (clearing === 1'b1 && n < clear_clocks) begin
      if (core_reset_n !== 1'b0) early++;
      @(negedge clk_sys);
      n++;
    end
    if (clearing !== 1'b0) report_problem("clearing did not fall");
    if (early != 0) report_problem("core_reset_n went high while clearing");
    wait_core_release(8);
    if (rom_mask !== expect_mask(rom_mem[idx], 1'b0))
      report_mismatch("rom_mask", 32'(expect_mask(rom_mem[idx], 1'b0)), 32'(rom_mask));
    if (ram_mask !== expect_mask(ram_mem[idx], 1'b1))
      report_mismatch("ram_mask", 32'(expect_mask(ram_mem[idx], 1'b1)), 32'(ram_mask));
    if (sram_size !== ram_mem[idx])
      report_mismatch("sram_size", 32'(ram_mem[idx]), 32'(sram_size));
  endtask

  task automatic test_spc();
    logic [apb_data_w-1:0] rdata;
    logic                  err;
    int                    start;
    start = clear_count;
    run_download(1'b0);
    // parser delay running right after the download ends
    apb_access(1'b0, reg_status_addr, '0, rdata, err);
    if (rdata[2] !== 1'b1) report_mismatch("status parser bit", 32'h1, 32'(rdata[2]));
    // past the parser delay
    repeat (12) @(negedge clk_sys);
    apb_access(1'b0, reg_status_addr, '0, rdata, err);
    if (rdata[2:1] !== 2'b01) report_mismatch("status spc bits", 32'h1, 32'(rdata[2:1]));
    wait_core_release(16);
    if (clear_count != start) report_problem("clearing rose during sound program load");
  endtask

  task automatic test_rfsh();
    int n;
    int count;
    n = 8 + int'($urandom % 24);
    count = 0;
    repeat (4 * n) begin
      @(negedge clk_sys);
      if (rfsh === 1'b1) count++;
    end
    if (count != n) report_mismatch("rfsh pulses", 32'(n), 32'(count));
  endtask

  initial begin
    int errors_before;
    clk_sys = 1'b0;
    reset = 1'b0;
    core_reset = 1'b1;
    cart_download = 1'b0;
    spc_download = 1'b0;
    ioctl_wr = 1'b0;
    rom_size = '0;
    ram_size = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    void'($urandom(seed));
    read_vectors();
    vectors_ready = 1'b1;
    apply_reset();
    core_reset = 1'b0;
    for (int i = 0; i < num_tests; i++) begin
      cur_name = name_mem[i];
      errors_before = error_count;
      repeat (2 + int'($urandom % 8)) @(negedge clk_sys);
      if (kind_mem[i] == "reset") test_reset();
      else if (kind_mem[i] == "apb") test_apb(wpat_mem[i], apat_mem[i]);
      else if (kind_mem[i] == "cart") test_cart(i);
      else if (kind_mem[i] == "spc") test_spc();
      else if (kind_mem[i] == "rfsh") test_rfsh();
      else report_problem($sformatf("unknown test kind %0s", kind_mem[i]));
      if (error_count == errors_before) begin
        pass_tests++;
        $display("test %0s: ok", cur_name);
      end else begin
        fail_tests++;
        $display("test %0s: %0d errors", cur_name, error_count - errors_before);
      end
    end
    if (num_tests == 0) report_problem("no tests found in vector file");
    $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // one full clear per test plus slack
  initial begin
    longint limit;
    wait (vectors_ready);
    limit = (longint'(num_tests) + 1) * (longint'(clear_clocks) + 4096) * clk_period;
    #(limit);
    $display("watchdog: run timed out after %0d time units", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== testbench/boot_vectors.txt ====
# name kind rom_size ram_size wram_pat aram_pat then fill_addr0..2 in hex
# kinds reset apb cart spc rfsh, unused fields are 0, addresses ascend
power_on reset 0 0 0 0 0 0 0
pattern_rw_a apb 0 0 1 2 0 0 0
pattern_rw_b apb 0 0 3 0 0 0 0
reset_clears_pattern reset 0 0 0 0 0 0 0
rfsh_idle rfsh 0 0 0 0 0 0 0
cart_checker cart 8 3 0 0 104 1fb 1fffe
spc_load spc 0 0 0 0 0 0 0
cart_after_spc cart 10 0 1 3 200 301 1ffff
cart_const_fill cart 12 5 3 2 100 8000 10000
rfsh_after_clear rfsh 0 0 0 0 0 0 0
cart_small_rom cart 0 1 2 0 1fb 204 1fffe
pattern_rw_c apb 0 0 2 1 0 0 0
rfsh_final rfsh 0 0 0 0 0 0 0

// ==== tb.f ====
verilog/boot_pkg.sv
verilog/load_tracker.sv
verilog/ram_clear.sv
verilog/reset_sequencer.sv
verilog/apb_settings.sv
verilog/cart_boot_top.sv
testbench/tb_cart_boot.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cart boot testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  -f tb.f \
  --top-module tb_cart_boot \
  -o tb_cart_boot

./obj_dir/tb_cart_boot | tee sim.log

if grep -qx "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi
